//--- Bender.yml
package:
  name: pinballBoard

sources:
  - hdl/cpuPkg.sv
  - hdl/boardPkg.sv
  - hdl/buttonConditioner.sv
  - hdl/regFile.sv
  - hdl/segmentScanner.sv
  - hdl/toneGenerator.sv
  - hdl/pinballBoard.sv
  - target: test
    files:
      - verif/pinballBoard_assert.sv
      - verif/pinballBoardTb.sv

//--- hdl/boardPkg.sv
`default_nettype none

package boardPkg;

	// Active-low segment pattern, bit 6 is g, bit 0 is a
	typedef logic [6:0] segments_t;

	// Active-low digit enables, one per display position
	typedef logic [7:0] anodes_t;

	// One bit per game button
	typedef logic [2:0] buttons_t;

	// Slide switches on the board
	typedef logic [6:0] switches_t;

	// Tone code, zero means silence
	typedef logic [3:0] pitch_t;

	// Everything the seven-segment display needs in one cycle
	typedef struct packed {
		segments_t segments;
		anodes_t   anodes;
	} display_t;

endpackage

`default_nettype wire

//--- hdl/buttonConditioner.sv
`timescale 1ns/1ps
`default_nettype none

module buttonConditioner #(
	parameter int DEBOUNCE_CYCLES = 500000
) (
	input  logic               clock,
	input  logic               rstN,
	input  boardPkg::buttons_t btn,
	input  boardPkg::buttons_t jaIn,
	output boardPkg::buttons_t buttons
);
	import boardPkg::*;

	localparam int NUM_BUTTONS = $bits(buttons_t);
	localparam int COUNT_WIDTH = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

	typedef logic [COUNT_WIDTH-1:0] count_t;

	buttons_t merged;
	buttons_t syncMeta;
	buttons_t syncStable;
	count_t   stableCount [NUM_BUTTONS];

	// Header pins are crossed over on buttons 0 and 1
	assign merged[0] = btn[0] | jaIn[1];
	assign merged[1] = btn[1] | jaIn[0];
	assign merged[2] = btn[2] | jaIn[2];

	// Two-flop synchronizer for the asynchronous pins
	always_ff @(posedge clock) begin
		if (!rstN) begin
			syncMeta   <= '0;
			syncStable <= '0;
		end else begin
			syncMeta   <= merged;
			syncStable <= syncMeta;
		end
	end

	// Per-button stability counter
	// Counts cycles where the input disagrees with the output
	always_ff @(posedge clock) begin
		if (!rstN) begin
			buttons <= '0;
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				stableCount[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_BUTTONS; i++) begin
				if (syncStable[i] == buttons[i]) begin
					// Any agreement restarts the window
					stableCount[i] <= '0;
				end else if (stableCount[i] == count_t'(DEBOUNCE_CYCLES - 1)) begin
					// Held long enough, accept the new level
					buttons[i]     <= syncStable[i];
					stableCount[i] <= '0;
				end else begin
					stableCount[i] <= stableCount[i] + count_t'(1);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Processor datapath word
	typedef logic [31:0] word_t;

	// Architectural register number, 32 registers
	typedef logic [4:0] regIndex_t;

	// One register-file write from the CPU
	// Applied at the clock edge while enable is high
	typedef struct packed {
		logic      enable;
		regIndex_t index;
		word_t     data;
	} regWrite_t;

endpackage

`default_nettype wire

//--- hdl/pinballBoard.sv
`timescale 1ns/1ps
`default_nettype none

module pinballBoard #(
	parameter int DEBOUNCE_CYCLES  = 500000,
	parameter int SCAN_CYCLES      = 50000,
	parameter int TONE_BASE_CYCLES = 2000
) (
	input  logic                clock,
	input  logic                rstN,

	// Board pins
	input  boardPkg::switches_t sw,
	input  boardPkg::buttons_t  btn,
	input  boardPkg::buttons_t  jaIn,
	output boardPkg::display_t  display,
	output logic [2:0]          led,
	output logic [2:0]          jaOut,
	output logic                audioPwm,
	output logic                audioEn,

	// CPU side
	input  cpuPkg::regWrite_t   regWrite,
	input  cpuPkg::regIndex_t   readIndexA,
	input  cpuPkg::regIndex_t   readIndexB,
	output cpuPkg::word_t       readDataA,
	output cpuPkg::word_t       readDataB,
	input  boardPkg::display_t  cpuDisplay,
	output boardPkg::buttons_t  buttons
);
	import cpuPkg::*;
	import boardPkg::*;

	// Register view for the switch-selected display
	regIndex_t  debugIndex;
	word_t      debugWord;

	// Register taps
	logic [2:0] ledTap;
	pitch_t     pitchTap;

	// Amplifier on whenever the board is out of reset
	assign audioEn = rstN;

	// LEDs mirrored on the header, bits 0 and 1 swapped
	assign led      = ledTap;
	assign jaOut[0] = led[1];
	assign jaOut[1] = led[0];
	assign jaOut[2] = led[2];

	// Buttons and header inputs into the CPU
	buttonConditioner #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_buttonConditioner (
		.clock  (clock),
		.rstN   (rstN),
		.btn    (btn),
		.jaIn   (jaIn),
		.buttons(buttons)
	);

	// Architectural registers
	regFile u_regFile (
		.clock     (clock),
		.rstN      (rstN),
		.regWrite  (regWrite),
		.readIndexA(readIndexA),
		.readIndexB(readIndexB),
		.readDataA (readDataA),
		.readDataB (readDataB),
		.debugIndex(debugIndex),
		.debugWord (debugWord),
		.ledTap    (ledTap),
		.pitchTap  (pitchTap)
	);

	// Seven-segment display, CPU pattern or register dump
	segmentScanner #(
		.SCAN_CYCLES(SCAN_CYCLES)
	) u_segmentScanner (
		.clock     (clock),
		.rstN      (rstN),
		.sw        (sw),
		.cpuDisplay(cpuDisplay),
		.debugIndex(debugIndex),
		.debugWord (debugWord),
		.display   (display)
	);

	// Sound from r1
	toneGenerator #(
		.TONE_BASE_CYCLES(TONE_BASE_CYCLES)
	) u_toneGenerator (
		.clock   (clock),
		.rstN    (rstN),
		.pitch   (pitchTap),
		.audioPwm(audioPwm)
	);

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic              clock,
	input  logic              rstN,
	input  cpuPkg::regWrite_t regWrite,
	input  cpuPkg::regIndex_t readIndexA,
	input  cpuPkg::regIndex_t readIndexB,
	output cpuPkg::word_t     readDataA,
	output cpuPkg::word_t     readDataB,
	input  cpuPkg::regIndex_t debugIndex,
	output cpuPkg::word_t     debugWord,
	output logic [2:0]        ledTap,
	output boardPkg::pitch_t  pitchTap
);
	import cpuPkg::*;

	localparam int REG_COUNT = 2 ** $bits(regIndex_t);

	// Game software keeps LED state in r22 and the tone code in r1
	localparam int LED_REG   = 22;
	localparam int PITCH_REG = 1;

	// No storage behind register zero
	word_t regs [1:REG_COUNT-1];

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 1; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite.enable && regWrite.index != '0) begin
			regs[regWrite.index] <= regWrite.data;
		end
	end

	// Zero register reads as constant zero
	function automatic word_t readReg(input regIndex_t index);
		word_t value;
		if (index == '0) begin
			value = '0;
		end else begin
			value = regs[index];
		end
		return value;
	endfunction

	// Three independent combinational read ports
	always_comb begin
		readDataA = readReg(readIndexA);
		readDataB = readReg(readIndexB);
		debugWord = readReg(debugIndex);
	end

	// Fixed taps for the board outputs
	assign ledTap   = regs[LED_REG][$bits(ledTap)-1:0];
	assign pitchTap = regs[PITCH_REG][$bits(pitchTap)-1:0];

endmodule

`default_nettype wire

//--- hdl/segmentScanner.sv
`timescale 1ns/1ps
`default_nettype none

module segmentScanner #(
	parameter int SCAN_CYCLES = 50000
) (
	input  logic                clock,
	input  logic                rstN,
	input  boardPkg::switches_t sw,
	input  boardPkg::display_t  cpuDisplay,
	output cpuPkg::regIndex_t   debugIndex,
	input  cpuPkg::word_t       debugWord,
	output boardPkg::display_t  display
);
	import boardPkg::*;
	import cpuPkg::*;

	localparam int PRESCALE_WIDTH = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
	localparam int NUM_DIGITS     = $bits(anodes_t);
	localparam int DIGIT_WIDTH    = $clog2(NUM_DIGITS);

	logic [PRESCALE_WIDTH-1:0] prescaleCount;
	logic [DIGIT_WIDTH-1:0]    digit;
	logic [3:0]                nibble;
	logic                      debugMode;
	segments_t                 hexSegments;
	anodes_t                   digitAnodes;

	// Any switch on selects the register view
	assign debugMode  = (sw != '0);
	assign debugIndex = sw[$bits(regIndex_t)-1:0];

	// Hex digit to active-low segments, g down to a
	function automatic segments_t hexDecode(input logic [3:0] value);
		segments_t pattern;
		case (value)
			4'h0:    pattern = 7'b1000000;
			4'h1:    pattern = 7'b1111001;
			4'h2:    pattern = 7'b0100100;
			4'h3:    pattern = 7'b0110000;
			4'h4:    pattern = 7'b0011001;
			4'h5:    pattern = 7'b0010010;
			4'h6:    pattern = 7'b0000010;
			4'h7:    pattern = 7'b1111000;
			4'h8:    pattern = 7'b0000000;
			4'h9:    pattern = 7'b0010000;
			4'hA:    pattern = 7'b0001000;
			4'hB:    pattern = 7'b0000011;
			4'hC:    pattern = 7'b1000110;
			4'hD:    pattern = 7'b0100001;
			4'hE:    pattern = 7'b0000110;
			default: pattern = 7'b0001110;
		endcase
		return pattern;
	endfunction

	// Prescaler and digit counter
	// Each digit stays lit for SCAN_CYCLES cycles
	always_ff @(posedge clock) begin
		if (!rstN) begin
			prescaleCount <= '0;
			digit         <= '0;
		end else if (prescaleCount == PRESCALE_WIDTH'(SCAN_CYCLES - 1)) begin
			prescaleCount <= '0;
			digit         <= digit + DIGIT_WIDTH'(1);
		end else begin
			prescaleCount <= prescaleCount + PRESCALE_WIDTH'(1);
		end
	end

	// Digit 0 shows the least significant nibble
	assign nibble      = debugWord[digit*4 +: 4];
	assign hexSegments = hexDecode(nibble);
	assign digitAnodes = ~(anodes_t'(1) << digit);

	// Registered output, blank out of reset
	always_ff @(posedge clock) begin
		if (!rstN) begin
			display <= '1;
		end else if (debugMode) begin
			display.segments <= hexSegments;
			display.anodes   <= digitAnodes;
		end else begin
			// CPU pattern passes straight through
			display <= cpuDisplay;
		end
	end

endmodule

`default_nettype wire

//--- hdl/toneGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module toneGenerator #(
	parameter int TONE_BASE_CYCLES = 2000
) (
	input  logic             clock,
	input  logic             rstN,
	input  boardPkg::pitch_t pitch,
	output logic             audioPwm
);
	import boardPkg::*;

	localparam int PITCH_STEPS = 2 ** $bits(pitch_t);
	localparam int LIMIT_WIDTH = $clog2(TONE_BASE_CYCLES * PITCH_STEPS);

	typedef logic [LIMIT_WIDTH-1:0] halfPeriod_t;

	pitch_t      lastPitch;
	halfPeriod_t halfPeriod;
	halfPeriod_t toneCount;
	logic        pitchChanged;

	// Higher code, shorter half-period
	assign halfPeriod   = halfPeriod_t'(TONE_BASE_CYCLES * (PITCH_STEPS - int'(pitch)));
	assign pitchChanged = (pitch != lastPitch);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			lastPitch <= '0;
			toneCount <= '0;
			audioPwm  <= 1'b0;
		end else begin
			lastPitch <= pitch;
			if (pitch == '0) begin
				// Silence
				toneCount <= '0;
				audioPwm  <= 1'b0;
			end else if (pitchChanged) begin
				// New note starts a fresh half-period
				toneCount <= '0;
			end else if (toneCount == halfPeriod - halfPeriod_t'(1)) begin
				toneCount <= '0;
				audioPwm  <= ~audioPwm;
			end else begin
				toneCount <= toneCount + halfPeriod_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

//--- pinballBoard.f
hdl/cpuPkg.sv
hdl/boardPkg.sv
hdl/buttonConditioner.sv
hdl/regFile.sv
hdl/segmentScanner.sv
hdl/toneGenerator.sv
hdl/pinballBoard.sv
verif/pinballBoard_assert.sv
verif/pinballBoardTb.sv

//--- verif/pinballBoardTb.sv
`timescale 1ns/1ps
`default_nettype none

module pinballBoardTb;
	import cpuPkg::*;
	import boardPkg::*;

	// Short counts so every window fits in a few hundred cycles
	localparam int DEBOUNCE  = 16;
	localparam int SCAN      = 4;
	localparam int TONE_BASE = 3;

	logic       clock, rstN, audioPwm, audioEn;
	logic [2:0] led, jaOut;
	switches_t  sw;
	buttons_t   btn, jaIn, buttons;
	display_t   display, cpuDisplay;
	regWrite_t  regWrite;
	regIndex_t  readIndexA, readIndexB;
	word_t      readDataA, readDataB;
	int         errorCount, timeoutCount;
	// Expected register contents, entry 0 never written
	word_t      shadow [32];

	pinballBoard #(
		.DEBOUNCE_CYCLES(DEBOUNCE), .SCAN_CYCLES(SCAN), .TONE_BASE_CYCLES(TONE_BASE)
	) u_pinballBoard (.*);

	always #5 clock = ~clock;

	// Active-low hex font, g down to a
	function automatic segments_t refHex(input logic [3:0] value);
		segments_t font [16];
		font = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
			7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
		return font[value];
	endfunction

	// Cycles between toggles
	function automatic int refHalfPeriod(input pitch_t code);
		return TONE_BASE * (16 - int'(code));
	endfunction

	// Header pins cross over on buttons 0 and 1
	function automatic buttons_t refButtons(input buttons_t b, input buttons_t j);
		return {b[2] | j[2], b[1] | j[0], b[0] | j[1]};
	endfunction

	task automatic checkWord(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Error in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkDisplay(input string name, input display_t expected,
		input display_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Error in %s: expected %b/%b, actual %b/%b", name, expected.segments,
				expected.anodes, actual.segments, actual.anodes);
		end
	endtask

	task automatic checkButtons(input string name, input buttons_t expected,
		input buttons_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Error in %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("Error in %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		$display("Timeout: %s", what);
	endtask

	// One-cycle write pulse, shadow follows the zero-register rule
	task automatic writeReg(input regIndex_t index, input word_t data);
		@(negedge clock);
		regWrite = {1'b1, index, data};
		@(negedge clock);
		regWrite.enable = 1'b0;
		if (index != '0) begin
			shadow[index] = data;
		end
	endtask

	// Bounded by the worst-case debounce latency
	task automatic waitButtons(input buttons_t expected);
		int cycles;
		cycles = 0;
		while (buttons !== expected && cycles < DEBOUNCE + 4) begin
			@(negedge clock);
			cycles++;
		end
		if (buttons !== expected) begin
			reportTimeout($sformatf("buttons stayed %b instead of %b", buttons, expected));
		end
	endtask

	// Cycles until the next audioPwm change
	task automatic measureEdge(input int limit, output int cycles);
		logic last;
		last   = audioPwm;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (audioPwm == last && cycles < limit);
		if (audioPwm == last) begin
			reportTimeout("audioPwm stopped toggling");
		end
	endtask

	initial begin
		regIndex_t  index;
		regIndex_t  other;
		word_t      data;
		buttons_t   seen;
		display_t   expected;
		logic [7:0] digitsSeen;
		int         digit;
		int         cycles;
		pitch_t     code;
		logic       heard;
		void'($urandom(32'h06383283));
		clock        = 1'b0;
		rstN         = 1'b0;
		sw           = '0;
		btn          = '0;
		jaIn         = '0;
		regWrite     = '0;
		readIndexA   = '0;
		readIndexB   = '0;
		cpuDisplay   = '0;
		errorCount   = 0;
		timeoutCount = 0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end

		// Eight cycles of reset, then blank display and quiet outputs
		repeat (8) @(negedge clock);
		rstN = 1'b1;
		#1;
		checkDisplay("reset display", '1, display);
		checkButtons("reset buttons", '0, buttons);
		checkBit("reset audioPwm", 1'b0, audioPwm);
		checkBit("reset audioEn", 1'b1, audioEn);

		// Every fifth write aims at register zero
		for (int i = 0; i < 40; i++) begin
			index = (i % 5 == 0) ? '0 : regIndex_t'($urandom_range(31, 1));
			other = regIndex_t'($urandom_range(31, 0));
			writeReg(index, $urandom());
			readIndexA = index;
			readIndexB = other;
			#1;
			checkWord("read port A", shadow[index], readDataA);
			checkWord("read port B", shadow[other], readDataB);
		end

		// r22 drives the LEDs, header copy swaps bits 0 and 1
		for (int i = 0; i < 4; i++) begin
			data = $urandom();
			writeReg(5'd22, data);
			#1;
			checkWord("led", word_t'(data[2:0]), word_t'(led));
			checkWord("jaOut", word_t'({data[2], data[0], data[1]}), word_t'(jaOut));
		end

		// Pulses shorter than the debounce window
		for (int i = 0; i < 4; i++) begin
			seen = '0;
			@(negedge clock);
			btn  = buttons_t'($urandom());
			jaIn = buttons_t'($urandom());
			repeat ($urandom_range(DEBOUNCE - 1, 1)) begin
				@(negedge clock);
				seen |= buttons;
			end
			btn  = '0;
			jaIn = '0;
			repeat (DEBOUNCE + 8) begin
				@(negedge clock);
				seen |= buttons;
			end
			checkButtons("short pulse", '0, seen);
		end
		// Held levels, each starting from the previous one
		for (int i = 0; i < 6; i++) begin
			@(negedge clock);
			btn  = buttons_t'($urandom());
			jaIn = buttons_t'($urandom());
			waitButtons(refButtons(btn, jaIn));
		end
		@(negedge clock);
		btn  = '0;
		jaIn = '0;
		waitButtons('0);

		// Switches off, CPU pattern one cycle late
		@(negedge clock);
		cpuDisplay = display_t'($urandom());
		for (int i = 0; i < 20; i++) begin
			expected = cpuDisplay;
			@(negedge clock);
			checkDisplay("cpu pass-through", expected, display);
			cpuDisplay = display_t'($urandom());
		end

		// Hex dump of a random register
		for (int r = 0; r < 3; r++) begin
			index = regIndex_t'($urandom_range(31, 1));
			data  = $urandom();
			writeReg(index, data);
			sw = {2'($urandom()), index};
			repeat (2) @(negedge clock);
			digitsSeen = '0;
			cycles     = 0;
			while (digitsSeen != '1 && cycles < SCAN * 8 * 3) begin
				@(negedge clock);
				cycles++;
				digit = 0;
				for (int d = 0; d < 8; d++) begin
					if (!display.anodes[d]) begin
						digit = d;
					end
				end
				// Only the lit position is low
				expected.segments      = refHex(data[digit*4 +: 4]);
				expected.anodes        = '1;
				expected.anodes[digit] = 1'b0;
				checkDisplay("hex digit", expected, display);
				digitsSeen[digit] = 1'b1;
			end
			if (digitsSeen != '1) begin
				reportTimeout($sformatf("only digits %b were lit", digitsSeen));
			end
		end
		sw = '0;

		// First edge only aligns the measurement
		for (int i = 0; i < 4; i++) begin
			code = pitch_t'($urandom_range(15, 1));
			writeReg(5'd1, ($urandom() & 32'hFFFF_FFF0) | word_t'(code));
			measureEdge(2 * refHalfPeriod(code) + 4, cycles);
			measureEdge(refHalfPeriod(code) + 4, cycles);
			checkWord("tone half-period", word_t'(refHalfPeriod(code)), word_t'(cycles));
		end
		// Code zero, output must stay low
		writeReg(5'd1, $urandom() & 32'hFFFF_FFF0);
		repeat (2) @(negedge clock);
		heard = 1'b0;
		repeat (4 * refHalfPeriod(pitch_t'(1))) begin
			@(negedge clock);
			heard |= audioPwm;
		end
		checkBit("silent tone", 1'b0, heard);

		$display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/pinballBoard_assert.sv
`timescale 1ns/1ps
`default_nettype none

module pinballBoardAssert (
	input logic                clock,
	input logic                rstN,
	input boardPkg::switches_t sw,
	input boardPkg::display_t  display,
	input boardPkg::pitch_t    pitchTap,
	input logic                audioPwm
);

	// Registered display lags the switches by one cycle
	anodeOneHot: assert property (@(posedge clock) disable iff (!rstN)
		($past(rstN) && $past(sw) != '0) |-> $onehot(~display.anodes))
		else $error("Switch view lights other than exactly one digit");

	// Silence takes effect one cycle after pitch reaches zero
	silentAtZero: assert property (@(posedge clock) disable iff (!rstN)
		($past(pitchTap) == '0) |-> !audioPwm)
		else $error("audioPwm high while pitch is zero");

	// Display still blank on the first cycle out of reset
	blankAfterReset: assert property (@(posedge clock) $rose(rstN) |-> display == '1)
		else $error("Display not blank after reset");

endmodule

bind pinballBoard pinballBoardAssert u_pinballBoardAssert (
	.clock   (clock),
	.rstN    (rstN),
	.sw      (sw),
	.display (display),
	.pitchTap(pitchTap),
	.audioPwm(audioPwm)
);

`default_nettype wire
